//--- bench/dcache_testdata.txt
# op amo addr wdata wstrb expected, all hex
# op 1 load 2 store 3 atomic; expected is the old word, 0 for stores
1 0 00000008 0000000000000000 00 F1BBCDCBFA53E0A8
1 0 00000010 0000000000000000 00 E3779B97F4A7C150
2 0 00000008 1122334455667788 0F 0000000000000000
1 0 00000008 0000000000000000 00 F1BBCDCB55667788
2 0 00000010 AAAAAAAAAAAAAAAA F0 0000000000000000
1 0 00000010 0000000000000000 00 AAAAAAAAF4A7C150
3 0 00000000 0000000000000005 FF 0000000000000000
3 1 00000000 0000000000000003 FF 0000000000000005
3 2 00000000 000000000000000F FF 0000000000000008
3 3 00000000 0000000000000030 FF 0000000000000007
3 4 00000000 00000000000000F0 FF 0000000000000037
3 5 00000000 FFFFFFFFFFFFFFFF FF 0000000000000030
3 6 00000000 0000000000000002 FF FFFFFFFFFFFFFFFF
3 7 00000000 FFFFFFFFFFFFFFF0 FF 0000000000000002
3 8 00000000 FFFFFFFFFFFFFFF0 FF 0000000000000002
1 0 00000000 0000000000000000 00 FFFFFFFFFFFFFFF0
1 0 00000800 0000000000000000 00 BBCDCBFA53E0A800
1 0 00000008 0000000000000000 00 F1BBCDCB55667788
1 0 00000000 0000000000000000 00 FFFFFFFFFFFFFFF0
1 0 00000010 0000000000000000 00 AAAAAAAAF4A7C150
2 0 00000800 0123456789ABCDEF FF 0000000000000000
1 0 00000008 0000000000000000 00 F1BBCDCB55667788
1 0 00000800 0000000000000000 00 0123456789ABCDEF
1 0 00000040 0000000000000000 00 8DDE6E5FD29F0540
3 1 00000040 0000000000000001 FF 8DDE6E5FD29F0540
1 0 00000040 0000000000000000 00 8DDE6E5FD29F0541

//--- src.f
common/dcache_pkg.sv
logic/line_ram.sv
logic/line_flags.sv
logic/amo_unit.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
bench/tb_clock.sv
bench/dcache_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary -j 0 -Wno-fatal
TOP       = dcache_tb
FILELIST  = src.f

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- bench/dcache_tb.sv
module dcache_tb import dcache_pkg::*; ();

    localparam int idx_w = 6;
    localparam int tag_w = addr_w - offset_w - idx_w;

    logic         CLK;
    logic         RST;
    cache_req_t   req;
    logic         ready;
    cache_resp_t  resp;
    l2_fill_req_t l2_fill;
    logic         fill_valid;
    line_t        fill_data;
    l2_wb_t       wb;
    logic         wb_done;

    word_t        l2_mem [int unsigned];
    word_t        ref_mem [int unsigned];
    logic         mv [2**idx_w];
    logic         md [2**idx_w];
    logic [tag_w-1:0] mt [2**idx_w];
    cache_req_t   stim_q [$];
    word_t        stim_exp_q [$];
    word_t        resp_q [$];
    l2_fill_req_t fill_q [$];
    l2_wb_t       wb_q [$];
    int           mismatches;
    int           other_errors;
    int           cycles;
    int           cycle_limit;

    tb_clock i_clock (.CLK(CLK), .RST(RST));

    dcache_top #(.line_count(2**idx_w)) i_dut (
        .CLK(CLK), .RST(RST), .req(req), .ready(ready), .resp(resp),
        .l2_fill(l2_fill), .fill_valid(fill_valid), .fill_data(fill_data),
        .wb(wb), .wb_done(wb_done)
    );

    function automatic word_t init_word(int unsigned widx);
        word_t a;
        a = word_t'(widx) * 8;
        return a * 64'h9E3779B97F4A7C15;
    endfunction

    function automatic word_t mem_word(ref word_t mem [int unsigned], input int unsigned widx);
        return mem.exists(widx) ? mem[widx] : init_word(widx);
    endfunction

    function automatic line_t ref_line(int unsigned line_addr);
        line_t l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w*word_w +: word_w] = mem_word(ref_mem, line_addr * words_per_line + w);
        end
        return l;
    endfunction

    // expected new word for a store or atomic
    function automatic word_t apply_op(cache_req_t r, word_t old);
        word_t n;
        n = old;
        if (r.op == op_store) begin
            for (int b = 0; b < 8; b++) begin
                if (r.wstrb[b]) n[b*8 +: 8] = r.wdata[b*8 +: 8];
            end
        end else if (r.op == op_amo) begin
            case (r.amo)
                amo_swap: n = r.wdata;
                amo_add:  n = old + r.wdata;
                amo_xor:  n = old ^ r.wdata;
                amo_or:   n = old | r.wdata;
                amo_and:  n = old & r.wdata;
                amo_min:  n = ($signed(old) < $signed(r.wdata)) ? old : r.wdata;
                amo_max:  n = ($signed(old) > $signed(r.wdata)) ? old : r.wdata;
                amo_minu: n = (old < r.wdata) ? old : r.wdata;
                amo_maxu: n = (old > r.wdata) ? old : r.wdata;
                default:  n = old;
            endcase
        end
        return n;
    endfunction

    task automatic check_resp(cache_resp_t got, word_t exp);
        if (got.rdata !== exp) begin
            $display("Mismatch at %0t: response %h, expected %h", $time, got.rdata, exp);
            mismatches++;
        end
    endtask

    task automatic check_fill(l2_fill_req_t got, l2_fill_req_t exp);
        if (got.line_addr !== exp.line_addr) begin
            $display("Mismatch at %0t: refill line %h, expected %h", $time,
                     got.line_addr, exp.line_addr);
            mismatches++;
        end
    endtask

    task automatic check_wb(l2_wb_t got, l2_wb_t exp);
        if (got.line_addr !== exp.line_addr || got.data !== exp.data) begin
            $display("Mismatch at %0t: write-back line %h data %h, expected %h data %h",
                     $time, got.line_addr, got.data, exp.line_addr, exp.data);
            mismatches++;
        end
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // update cache and memory models when a request is taken
    task automatic accept_model(cache_req_t r, word_t file_exp);
        int unsigned widx;
        logic [idx_w-1:0] idx;
        logic [tag_w-1:0] tag;
        l2_wb_t w;
        l2_fill_req_t f;
        widx = r.addr >> 3;
        idx = r.addr[offset_w +: idx_w];
        tag = r.addr[addr_w-1 -: tag_w];
        if (!(mv[idx] && mt[idx] == tag)) begin
            if (mv[idx] && md[idx]) begin
                w.valid = 1'b1;
                w.line_addr = {mt[idx], idx};
                w.data = ref_line({mt[idx], idx});
                wb_q.push_back(w);
            end
            f.valid = 1'b1;
            f.line_addr = r.addr[addr_w-1:offset_w];
            fill_q.push_back(f);
            mv[idx] = 1'b1;
            mt[idx] = tag;
            md[idx] = 1'b0;
        end
        if (r.op != op_load) md[idx] = 1'b1;
        if (r.op != op_store) begin
            check_word(file_exp, mem_word(ref_mem, widx), "data file word");
            resp_q.push_back(mem_word(ref_mem, widx));
        end
        ref_mem[widx] = apply_op(r, mem_word(ref_mem, widx));
    endtask

    task automatic send_req(cache_req_t r);
        req <= r;
        @(negedge CLK);
        while (!ready) @(negedge CLK);
        @(posedge CLK);
    endtask

    task automatic read_request_file();
        int fd;
        string text;
        int unsigned op_v, amo_v, addr_v, strb_v;
        word_t wdata_v, exp_v;
        cache_req_t r;
        fd = $fopen("bench/dcache_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            other_errors++;
            return;
        end
        while ($fgets(text, fd) > 0) begin
            if (text.len() < 2 || text.getc(0) == "#") continue;
            if ($sscanf(text, "%h %h %h %h %h %h", op_v, amo_v, addr_v, wdata_v,
                        strb_v, exp_v) == 6) begin
                r.valid = 1'b1;
                r.op = op_e'(op_v);
                r.amo = amo_e'(amo_v);
                r.addr = addr_v;
                r.wdata = wdata_v;
                r.wstrb = strb_v[strb_w-1:0];
                stim_q.push_back(r);
                stim_exp_q.push_back(exp_v);
            end
        end
        $fclose(fd);
    endtask

    always @(negedge CLK) begin
        if (!RST && resp.valid) begin
            if (resp_q.size() == 0) begin
                $display("response at %0t with no request waiting for one", $time);
                other_errors++;
            end else begin
                check_resp(resp, resp_q.pop_front());
            end
        end
    end

    // l2 model serving one transfer at a time
    always begin
        @(negedge CLK);
        if (!RST && wb.valid) begin
            if (wb_q.size() == 0) begin
                $display("write-back at %0t that was not expected", $time);
                other_errors++;
            end else begin
                check_wb(wb, wb_q.pop_front());
            end
            for (int w = 0; w < words_per_line; w++) begin
                l2_mem[wb.line_addr * words_per_line + w] = wb.data[w*word_w +: word_w];
            end
            repeat ($urandom_range(1, 4)) @(posedge CLK);
            wb_done <= 1'b1;
            @(posedge CLK);
            wb_done <= 1'b0;
        end else if (!RST && l2_fill.valid) begin
            if (fill_q.size() == 0) begin
                $display("refill at %0t that was not expected", $time);
                other_errors++;
            end else begin
                check_fill(l2_fill, fill_q.pop_front());
            end
            repeat ($urandom_range(1, 4)) @(posedge CLK);
            fill_valid <= 1'b1;
            for (int w = 0; w < words_per_line; w++) begin
                fill_data[w*word_w +: word_w] <=
                    mem_word(l2_mem, l2_fill.line_addr * words_per_line + w);
            end
            @(posedge CLK);
            fill_valid <= 1'b0;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles with requests still open", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        req = '0;
        fill_valid = 1'b0;
        fill_data = '0;
        wb_done = 1'b0;
        mismatches = 0;
        other_errors = 0;
        cycles = 0;
        cycle_limit = 0;
        void'($urandom(11504));
        for (int i = 0; i < 2**idx_w; i++) begin
            mv[i] = 1'b0;
            md[i] = 1'b0;
            mt[i] = '0;
        end
        read_request_file();
        cycle_limit = 200 * (stim_q.size() + 1);
        @(negedge CLK);
        while (RST) @(negedge CLK);
        if (!ready || resp.valid || l2_fill.valid || wb.valid) begin
            $display("outputs not idle after reset");
            other_errors++;
        end
        @(posedge CLK);
        for (int i = 0; i < stim_q.size(); i++) begin
            send_req(stim_q[i]);
            accept_model(stim_q[i], stim_exp_q[i]);
        end
        req <= '0;
        @(negedge CLK);
        while (resp_q.size() != 0 || fill_q.size() != 0 || wb_q.size() != 0 || !ready) begin
            @(negedge CLK);
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock.sv
module tb_clock (
    output logic CLK,
    output logic RST
);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // reset held for three rising edges
    initial begin
        RST = 1'b1;
        repeat (3) @(posedge CLK);
        RST <= 1'b0;
    end

endmodule

//--- dcache/dcache_top.sv
module dcache_top import dcache_pkg::*; #(
    parameter int line_count = 64
) (
    input  logic         CLK,
    input  logic         RST,
    input  cache_req_t   req,
    output logic         ready,
    output cache_resp_t  resp,
    output l2_fill_req_t l2_fill,
    input  logic         fill_valid,
    input  line_t        fill_data,
    output l2_wb_t       wb,
    input  logic         wb_done
);

    localparam int idx_w = $clog2(line_count);
    localparam int tag_w = tag_bits(line_count);

    line_t            data_rd;
    line_t            data_wr;
    logic [tag_w-1:0] tag_rd;
    logic [tag_w-1:0] tag_wr;
    logic [idx_w-1:0] ram_rd_idx;
    logic [idx_w-1:0] ram_wr_idx;
    logic             ram_wr_en;
    logic             valid_bit;
    logic             dirty_bit;
    logic             set_valid;
    logic             set_dirty;
    logic             clear_dirty;
    word_t            old_word;
    word_t            new_word;
    cache_req_t       cur_req;

    dcache_ctrl #(
        .line_count(line_count)
    ) i_ctrl (
        .CLK         (CLK),
        .RST         (RST),
        .req         (req),
        .ready       (ready),
        .resp        (resp),
        .l2_fill     (l2_fill),
        .fill_valid  (fill_valid),
        .fill_data   (fill_data),
        .wb          (wb),
        .wb_done     (wb_done),
        .data_rd     (data_rd),
        .tag_rd      (tag_rd),
        .valid_bit   (valid_bit),
        .dirty_bit   (dirty_bit),
        .ram_rd_idx  (ram_rd_idx),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_idx  (ram_wr_idx),
        .data_wr     (data_wr),
        .tag_wr      (tag_wr),
        .set_valid   (set_valid),
        .set_dirty   (set_dirty),
        .clear_dirty (clear_dirty),
        .old_word    (old_word),
        .new_word    (new_word),
        .cur_req     (cur_req)
    );

    line_ram #(
        .line_count(line_count),
        .width     (line_w)
    ) data_ram (
        .CLK     (CLK),
        .rd_idx  (ram_rd_idx),
        .rd_data (data_rd),
        .wr_en   (ram_wr_en),
        .wr_idx  (ram_wr_idx),
        .wr_data (data_wr)
    );

    line_ram #(
        .line_count(line_count),
        .width     (tag_w)
    ) tag_ram (
        .CLK     (CLK),
        .rd_idx  (ram_rd_idx),
        .rd_data (tag_rd),
        .wr_en   (ram_wr_en),
        .wr_idx  (ram_wr_idx),
        .wr_data (tag_wr)
    );

    line_flags #(
        .line_count(line_count)
    ) i_flags (
        .CLK         (CLK),
        .RST         (RST),
        .rd_idx      (ram_rd_idx),
        .valid_bit   (valid_bit),
        .dirty_bit   (dirty_bit),
        .wr_idx      (ram_wr_idx),
        .set_valid   (set_valid),
        .set_dirty   (set_dirty),
        .clear_dirty (clear_dirty)
    );

    amo_unit i_amo (
        .op       (cur_req.op),
        .amo      (cur_req.amo),
        .old_word (old_word),
        .wdata    (cur_req.wdata),
        .wstrb    (cur_req.wstrb),
        .new_word (new_word)
    );

endmodule

//--- dcache/dcache_ctrl.sv
module dcache_ctrl import dcache_pkg::*; #(
    parameter int line_count = 64,
    localparam int idx_w = $clog2(line_count),
    localparam int tag_w = tag_bits(line_count)
) (
    input  logic             CLK,
    input  logic             RST,
    input  cache_req_t       req,
    output logic             ready,
    output cache_resp_t      resp,
    output l2_fill_req_t     l2_fill,
    input  logic             fill_valid,
    input  line_t            fill_data,
    output l2_wb_t           wb,
    input  logic             wb_done,
    input  line_t            data_rd,
    input  logic [tag_w-1:0] tag_rd,
    input  logic             valid_bit,
    input  logic             dirty_bit,
    output logic [idx_w-1:0] ram_rd_idx,
    output logic             ram_wr_en,
    output logic [idx_w-1:0] ram_wr_idx,
    output line_t            data_wr,
    output logic [tag_w-1:0] tag_wr,
    output logic             set_valid,
    output logic             set_dirty,
    output logic             clear_dirty,
    output word_t            old_word,
    input  word_t            new_word,
    output cache_req_t       cur_req
);

    localparam int sel_lo = $clog2(strb_w);

    typedef enum logic [2:0] {
        idle,
        write_back,
        wait_wb,
        refill,
        replay
    } state_e;

    state_e                     state;
    cache_req_t                 s1_req;
    cache_req_t                 s2_req;
    logic                       fwd_valid;
    logic [idx_w-1:0]           fwd_idx;
    line_t                      fwd_line;
    line_t                      cur_line;
    logic [idx_w-1:0]           s2_idx;
    logic [tag_w-1:0]           s2_tag;
    logic [offset_w-sel_lo-1:0] s2_sel;
    logic                       need;
    logic                       hit;
    logic                       advance;
    logic                       miss;
    logic                       wr_hit;
    logic                       fill_wr;

    assign s2_idx = s2_req.addr[offset_w +: idx_w];
    assign s2_tag = s2_req.addr[addr_w-1 -: tag_w];
    assign s2_sel = s2_req.addr[offset_w-1:sel_lo];

    // ram read misses a write made on the same edge
    assign cur_line = (fwd_valid && fwd_idx == s2_idx) ? fwd_line : data_rd;
    assign old_word = cur_line[s2_sel*word_w +: word_w];
    assign cur_req = s2_req;

    assign need = s2_req.valid && s2_req.op != op_none;
    assign hit = valid_bit && tag_rd == s2_tag;
    assign advance = state == idle && (!need || hit);
    assign miss = state == idle && need && !hit;
    assign wr_hit = state == idle && need && hit && s2_req.op != op_load;
    assign fill_wr = state == refill && fill_valid;
    assign ready = advance;

    // index that stage 2 holds after the next edge
    assign ram_rd_idx = advance ? s1_req.addr[offset_w +: idx_w] : s2_idx;
    assign ram_wr_idx = s2_idx;
    assign ram_wr_en = wr_hit || fill_wr;
    assign tag_wr = s2_tag;
    assign set_valid = fill_wr;
    assign clear_dirty = fill_wr;
    assign set_dirty = wr_hit;

    always_comb begin
        data_wr = cur_line;
        if (state == refill) begin
            data_wr = fill_data;
        end else begin
            data_wr[s2_sel*word_w +: word_w] = new_word;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            s1_req.valid <= 1'b0;
            s2_req.valid <= 1'b0;
        end else if (advance) begin
            s1_req <= req;
            s2_req <= s1_req;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            fwd_valid <= 1'b0;
        end else begin
            fwd_valid <= ram_wr_en;
        end
        fwd_idx <= ram_wr_idx;
        fwd_line <= data_wr;
    end

    // stores complete silently
    always_ff @(posedge CLK) begin
        if (RST) begin
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= advance && need && s2_req.op != op_store;
        end
        resp.rdata <= old_word;
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= idle;
            l2_fill.valid <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            l2_fill.valid <= 1'b0;
            wb.valid <= 1'b0;
            case (state)
                idle: begin
                    if (miss) begin
                        l2_fill.line_addr <= s2_req.addr[addr_w-1:offset_w];
                        if (valid_bit && dirty_bit) begin
                            wb.valid <= 1'b1;
                            wb.line_addr <= {tag_rd, s2_idx};
                            wb.data <= cur_line;
                            state <= write_back;
                        end else begin
                            l2_fill.valid <= 1'b1;
                            state <= refill;
                        end
                    end
                end
                write_back, wait_wb: begin
                    // victim must land in l2 before the refill read
                    if (wb_done) begin
                        l2_fill.valid <= 1'b1;
                        state <= refill;
                    end else begin
                        state <= wait_wb;
                    end
                end
                refill: begin
                    if (fill_valid) begin
                        state <= replay;
                    end
                end
                replay: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

//--- logic/amo_unit.sv
module amo_unit import dcache_pkg::*; (
    input  op_e               op,
    input  amo_e              amo,
    input  word_t             old_word,
    input  word_t             wdata,
    input  logic [strb_w-1:0] wstrb,
    output word_t             new_word
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed = $signed(wdata) < $signed(old_word);
    assign lt_unsigned = wdata < old_word;

    always_comb begin
        new_word = old_word;
        case (op)
            op_store: begin
                // byte merge by strobe
                for (int i = 0; i < strb_w; i++) begin
                    if (wstrb[i]) begin
                        new_word[i*8 +: 8] = wdata[i*8 +: 8];
                    end
                end
            end
            op_amo: begin
                case (amo)
                    amo_swap: new_word = wdata;
                    amo_add:  new_word = old_word + wdata;
                    amo_xor:  new_word = old_word ^ wdata;
                    amo_or:   new_word = old_word | wdata;
                    amo_and:  new_word = old_word & wdata;
                    amo_min:  new_word = lt_signed ? wdata : old_word;
                    amo_max:  new_word = lt_signed ? old_word : wdata;
                    amo_minu: new_word = lt_unsigned ? wdata : old_word;
                    amo_maxu: new_word = lt_unsigned ? old_word : wdata;
                    default:  new_word = old_word;
                endcase
            end
            default: begin
                new_word = old_word;
            end
        endcase
    end

endmodule

//--- logic/line_flags.sv
module line_flags #(
    parameter int line_count = 64,
    localparam int idx_w = $clog2(line_count)
) (
    input  logic             CLK,
    input  logic             RST,
    input  logic [idx_w-1:0] rd_idx,
    output logic             valid_bit,
    output logic             dirty_bit,
    input  logic [idx_w-1:0] wr_idx,
    input  logic             set_valid,
    input  logic             set_dirty,
    input  logic             clear_dirty
);

    logic [line_count-1:0] valid_q;
    logic [line_count-1:0] dirty_q;
    logic [idx_w-1:0]      rd_idx_q;

    always_ff @(posedge CLK) begin
        rd_idx_q <= rd_idx;
    end

    // flag reads see writes from the same edge
    assign valid_bit = valid_q[rd_idx_q];
    assign dirty_bit = dirty_q[rd_idx_q];

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (set_valid) begin
                valid_q[wr_idx] <= 1'b1;
            end
            if (clear_dirty) begin
                dirty_q[wr_idx] <= 1'b0;
            end else if (set_dirty) begin
                dirty_q[wr_idx] <= 1'b1;
            end
        end
    end

endmodule

//--- logic/line_ram.sv
module line_ram #(
    parameter int line_count = 64,
    parameter int width = 256,
    localparam int idx_w = $clog2(line_count)
) (
    input  logic             CLK,
    input  logic [idx_w-1:0] rd_idx,
    output logic [width-1:0] rd_data,
    input  logic             wr_en,
    input  logic [idx_w-1:0] wr_idx,
    input  logic [width-1:0] wr_data
);

    logic [width-1:0] mem [line_count];

    // read returns the old entry on a same-index write
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
        rd_data <= mem[rd_idx];
    end

endmodule

//--- common/dcache_pkg.sv
package dcache_pkg;

    localparam int word_w = 64;
    localparam int addr_w = 32;
    localparam int words_per_line = 4;
    localparam int strb_w = word_w / 8;
    localparam int offset_w = $clog2(words_per_line * strb_w);
    localparam int line_w = words_per_line * word_w;
    localparam int line_addr_w = addr_w - offset_w;

    typedef logic [word_w-1:0] word_t;
    typedef logic [line_w-1:0] line_t;

    typedef enum logic [1:0] {
        op_none,
        op_load,
        op_store,
        op_amo
    } op_e;

    typedef enum logic [3:0] {
        amo_swap,
        amo_add,
        amo_xor,
        amo_or,
        amo_and,
        amo_min,
        amo_max,
        amo_minu,
        amo_maxu
    } amo_e;

    typedef struct packed {
        logic              valid;
        op_e               op;
        amo_e              amo;
        logic [addr_w-1:0] addr;
        word_t             wdata;
        logic [strb_w-1:0] wstrb;
    } cache_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } cache_resp_t;

    typedef struct packed {
        logic                   valid;
        logic [line_addr_w-1:0] line_addr;
    } l2_fill_req_t;

    typedef struct packed {
        logic                   valid;
        logic [line_addr_w-1:0] line_addr;
        line_t                  data;
    } l2_wb_t;

    // tag bits left over once index and offset are taken
    function automatic int tag_bits(input int lines);
        return addr_w - offset_w - $clog2(lines);
    endfunction

endpackage
